// ==== sim/if_id_golden.txt ====
# command  reg_value  id_reg  decoded_command  (all hex)
# decoded_command = opcode rs rt rd imm mem_addr tag, 88 bits
00221800 deadbeef 00 0022180000000000000002
07feefff deadbeef 00 07fee80000000000000002
08aa7923 deadbeef 00 08aa780000000000000002
0c000000 00000000 00 0c00000000000000000002
12082000 5a5a5a5a 00 1208200000000000000002
146758aa 5a5a5a5a 00 1467580000000000000002
ad32d800 5a5a5a5a 00 ad32d80000000000000002
38853044 ffffffff 00 3885300000000000000003
3d8d7000 ffffffff 00 3d8d700000000000000003
582415a5 00000001 00 5824100000000000000002
5c432000 00000001 00 5c43200000000000000002
60e14800 00000001 00 60e1480000000000000002
6542a000 00000001 00 6542a00000000000000002
7a33a8f0 a5a5a5a5 00 7a33a80000000000000002
7ed7c000 a5a5a5a5 00 7ed7c00000000000000002
40c740ff 0f0f0f0f 00 40c0400000000000000003
47ffffff 0f0f0f0f 00 47e0f80000000000000003
a8692800 0f0f0f0f 00 a860280000000000000002
b1018000 0f0f0f0f 00 b100800000000000000002
4b3adbcc 12345678 00 4b20000000000000000003
4fef3801 12345678 00 4fe0000000000000000002
716c6800 12345678 00 7000680000000000000002
7421f7ff 12345678 00 7400f00000000000000002
18431234 deadbeef 00 184018000091a000000002
1ff1ffff deadbeef 00 1fe0880007fff800000002
201f8001 deadbeef 00 2000f80004000800000002
24babcde 00000000 00 24002800d5e6f000000006
27ffffff ffffffff 00 2400f800fffff800000006
28890010 12345678 09 2804480000000091a2b3c1
2fffffff ffffffff 1f 2c1ff800000007fffffff9
30010003 80000000 01 3000080000000400000001
368a1234 cafef00d 0a 3414500000000657f78069
68642800 11111111 00 6800000000000000000003
6fffffff ffffffff 00 6c00000000000000000002
80221800 deadbeef 00 0000000000000000000000
a7ffffff ffffffff 00 0000000000000000000000
94421800 deadbeef 00 0000000000000000000000
50a5a5a5 deadbeef 00 0000000000000000000000
57ffffff ffffffff 00 0000000000000000000000
b4221800 deadbeef 00 0000000000000000000000
ffffffff ffffffff 00 0000000000000000000000
00221800 deadbeef 00 0022180000000000000002

// ==== build.f ====
+incdir+logic
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/op_classifier.sv
logic/operand_router.sv
logic/if_id.sv
sim/tb_if_id.sv

// ==== Bender.yml ====
package:
  name: if_id

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/decode_pkg.sv
      - logic/op_classifier.sv
      - logic/operand_router.sv
      - logic/if_id.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_if_id.sv

// ==== sim/tb_if_id.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage testbench with clock and reset, golden vector reader,
// stimulus, typed compare tasks and the closing report
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

module tb_if_id;

    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 50;    // cycles
    localparam int MAX_LINES     = 1000;  // bound on the golden file read
    localparam int DRIVE_DELAY   = 1;     // after the rising edge
    localparam logic [`IF_ID_WORD_W-1:0] RESET_WORD = 32'h2889_0010;  // lw held during reset

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic [`IF_ID_WORD_W-1:0] command;
    logic [`IF_ID_WORD_W-1:0] id_reg_search;
    decode_pkg::reg_addr_t    id_reg;
    decode_pkg::dec_cmd_t     command_next;

    int reg_errors   = 0;
    int cmd_errors   = 0;
    int other_errors = 0;
    int reset_edges  = 0;

    if_id i_dut (
        .clk           (clk),
        .rst           (rst),
        .command       (command),
        .id_reg_search (id_reg_search),
        .id_reg        (id_reg),
        .command_next  (command_next)
    );

    always #2 clk = ~clk;

    // rst drops just after the last reset edge
    always @(posedge clk) begin
        if (reset_edges < RESET_CYCLES) begin
            reset_edges = reset_edges + 1;
        end
        #DRIVE_DELAY;
        rst = (reset_edges < RESET_CYCLES);
    end

    task automatic check_reg(input string name, input decode_pkg::reg_addr_t got,
                             input decode_pkg::reg_addr_t want, input int vec);
        if (got !== want) begin
            reg_errors++;
            $display("FAILED %s vector %0d: got %h expected %h", name, vec, got, want);
        end
    endtask

    task automatic check_cmd(input string name, input decode_pkg::dec_cmd_t got,
                             input decode_pkg::dec_cmd_t want, input int vec);
        if (got !== want) begin
            cmd_errors++;
            $display("FAILED %s vector %0d: got %h expected %h", name, vec, got, want);
        end
    endtask

    initial begin : main_seq
        int                       fd;
        int                       c;
        int                       lines;
        int                       vectors;
        int                       fields;
        int                       guard;
        logic [`IF_ID_WORD_W-1:0] v_command;
        logic [`IF_ID_WORD_W-1:0] v_reg_value;
        decode_pkg::reg_addr_t    v_id_reg;
        decode_pkg::dec_cmd_t     v_cmd;

        command       = RESET_WORD;
        id_reg_search = 32'h1357_9bdf;

        // command_next stays clear while rst is high
        guard = 0;
        do begin
            @(negedge clk);
            check_cmd("command_next", command_next, '0, guard);
            guard++;
        end while (rst && guard < RESET_TIMEOUT);

        if (rst) begin
            other_errors++;
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        end else begin
            fd = $fopen("sim/if_id_golden.txt", "r");
            if (fd == 0) begin
                other_errors++;
                $display("Could not open the golden vector file");
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
                lines   = 0;
                vectors = 0;
                while (lines < MAX_LINES) begin
                    fields = $fscanf(fd, "%h %h %h %h",
                                     v_command, v_reg_value, v_id_reg, v_cmd);
                    if (fields < 0 || (fields == 0 && $feof(fd))) begin
                        break;  // end of file
                    end
                    lines++;
                    if (fields == 0) begin
                        c = $fgetc(fd);
                        if (c != "#") begin
                            other_errors++;
                            $display("Golden file line %0d holds no hex values", lines);
                            break;
                        end
                        while (c != "\n" && c != -1) begin  // rest of the column notes
                            c = $fgetc(fd);
                        end
                        continue;
                    end
                    if (fields != 4) begin
                        other_errors++;
                        $display("Golden file line %0d does not hold four values", lines);
                        break;
                    end
                    command       = v_command;
                    id_reg_search = v_reg_value;
                    @(negedge clk);
                    check_reg("id_reg", id_reg, v_id_reg, vectors);  // same cycle
                    @(posedge clk);
                    #DRIVE_DELAY;
                    check_cmd("command_next", command_next, v_cmd, vectors);
                    vectors++;
                end
                if (lines >= MAX_LINES) begin
                    other_errors++;
                    $display("Golden file read stopped after %0d lines", MAX_LINES);
                end
                $fclose(fd);
                if (vectors == 0) begin
                    other_errors++;
                    $display("No vectors were found in the golden file");
                end
            end
        end

        $display("errors: id_reg %0d, command_next %0d, other %0d",
                 reg_errors, cmd_errors, other_errors);
        if (reg_errors + cmd_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/if_id.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction decode stage top: opcode classifier, operand router
// and the registered decoded command
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

module if_id (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`IF_ID_WORD_W-1:0] command,
    input  logic [`IF_ID_WORD_W-1:0] id_reg_search,  // read data for id_reg
    output decode_pkg::reg_addr_t    id_reg,
    output decode_pkg::dec_cmd_t     command_next
);

    isa_pkg::op_format_e  format;
    isa_pkg::route_tag_e  tag;
    decode_pkg::dec_cmd_t cmd_d;

    op_classifier i_op_classifier (
        .opcode (command[`IF_ID_WORD_W-1 -: `IF_ID_OP_W]),
        .format (format),
        .tag    (tag)
    );

    operand_router i_operand_router (
        .command       (command),
        .format        (format),
        .tag           (tag),
        .id_reg_search (id_reg_search),
        .id_reg        (id_reg),
        .cmd_d         (cmd_d)
    );

    // one pipeline register, new command every edge
    always_ff @(posedge clk) begin
        if (rst) begin
            command_next <= '0;
        end else begin
            command_next <= cmd_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/operand_router.sv ====
////////////////////////////////////////////////////////////////////////////
// Operand router: builds the decoded command from the operand format
// and issues the register read for memory operations
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

module operand_router (
    input  logic [`IF_ID_WORD_W-1:0] command,
    input  isa_pkg::op_format_e      format,
    input  isa_pkg::route_tag_e      tag,
    input  logic [`IF_ID_WORD_W-1:0] id_reg_search,
    output decode_pkg::reg_addr_t    id_reg,
    output decode_pkg::dec_cmd_t     cmd_d
);

    // field positions inside the instruction word
    localparam int OP_LSB = `IF_ID_WORD_W - `IF_ID_OP_W;    // 26
    localparam int RS_LSB = OP_LSB - `IF_ID_REG_AW;          // 21
    localparam int RT_LSB = RS_LSB - `IF_ID_REG_AW;          // 16
    localparam int RD_LSB = RT_LSB - `IF_ID_REG_AW;          // 11

    decode_pkg::reg_addr_t rs_f;
    decode_pkg::reg_addr_t rt_f;
    decode_pkg::reg_addr_t rd_f;
    decode_pkg::word_t     imm16_zx;
    decode_pkg::word_t     imm21_zx;

    assign rs_f = command[RS_LSB +: `IF_ID_REG_AW];
    assign rt_f = command[RT_LSB +: `IF_ID_REG_AW];
    assign rd_f = command[RD_LSB +: `IF_ID_REG_AW];

    assign imm16_zx = {{(`IF_ID_WORD_W-`IF_ID_IMM_W){1'b0}}, command[`IF_ID_IMM_W-1:0]};
    assign imm21_zx = {{(`IF_ID_WORD_W-`IF_ID_LUI_W){1'b0}}, command[`IF_ID_LUI_W-1:0]};

    always_comb begin
        cmd_d  = '0;
        id_reg = '0;
        if (tag != isa_pkg::INVALID) begin  // unknown opcode leaves all zero
            cmd_d.opcode = command[OP_LSB +: `IF_ID_OP_W];
            cmd_d.tag    = tag;
            case (format)
                isa_pkg::FMT_R3: begin
                    cmd_d.rs = rs_f;
                    cmd_d.rt = rt_f;
                    cmd_d.rd = rd_f;
                end
                isa_pkg::FMT_R2: begin
                    cmd_d.rs = rs_f;
                    cmd_d.rd = rd_f;
                end
                isa_pkg::FMT_RD_ONLY: cmd_d.rd = rd_f;
                isa_pkg::FMT_RS_ONLY: cmd_d.rs = rs_f;
                isa_pkg::FMT_IMM: begin
                    cmd_d.rs  = rs_f;
                    cmd_d.rd  = rt_f;   // destination in bits 20..16
                    cmd_d.imm = imm16_zx;
                end
                isa_pkg::FMT_LUI: begin
                    cmd_d.rd  = rs_f;   // destination in bits 25..21
                    cmd_d.imm = imm21_zx;
                end
                isa_pkg::FMT_MEM: begin
                    cmd_d.rt       = rs_f;
                    cmd_d.rd       = rt_f;
                    id_reg         = rt_f;            // same-cycle register read
                    cmd_d.mem_addr = id_reg_search;
                end
                default: ;  // SYSCALL, BREAK keep only opcode and tag
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/op_classifier.sv ====
////////////////////////////////////////////////////////////////////////////
// Opcode classifier: maps the major opcode to an operand format
// and a route tag, one table for the whole instruction set
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

module op_classifier (
    input  logic [`IF_ID_OP_W-1:0] opcode,
    output isa_pkg::op_format_e    format,
    output isa_pkg::route_tag_e    tag
);

    always_comb begin
        format = isa_pkg::FMT_NONE;  // unknown and floating point
        tag    = isa_pkg::INVALID;
        case (isa_pkg::opcode_e'(opcode))
            // three register ops
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
            isa_pkg::OP_OR, isa_pkg::OP_XOR, isa_pkg::OP_SLT,
            isa_pkg::OP_NOR: begin
                format = isa_pkg::FMT_R3;
                tag    = isa_pkg::EXEC;
            end
            isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA,
            isa_pkg::OP_SLA: begin
                format = isa_pkg::FMT_R3;  // shift amount sits in rt
                tag    = isa_pkg::EXEC;
            end
            isa_pkg::OP_MULT, isa_pkg::OP_DIV: begin
                format = isa_pkg::FMT_R3;
                tag    = isa_pkg::EXEC;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                format = isa_pkg::FMT_R3;
                tag    = isa_pkg::FLOW;
            end
            // two register ops
            isa_pkg::OP_BLEZ, isa_pkg::OP_BGTZ: begin
                format = isa_pkg::FMT_R2;
                tag    = isa_pkg::FLOW;
            end
            isa_pkg::OP_MOV, isa_pkg::OP_NOT: begin
                format = isa_pkg::FMT_R2;
                tag    = isa_pkg::EXEC;
            end
            // immediates
            isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI: begin
                format = isa_pkg::FMT_IMM;
                tag    = isa_pkg::EXEC;
            end
            isa_pkg::OP_LUI: begin
                format = isa_pkg::FMT_LUI;
                tag    = isa_pkg::LUI_PATH;
            end
            isa_pkg::OP_LW, isa_pkg::OP_SW, isa_pkg::OP_LB, isa_pkg::OP_SB: begin
                format = isa_pkg::FMT_MEM;
                tag    = isa_pkg::MEM_PATH;
            end
            // jumps carry the target register only
            isa_pkg::OP_J: begin
                format = isa_pkg::FMT_RS_ONLY;
                tag    = isa_pkg::FLOW;
            end
            isa_pkg::OP_JAL: begin
                format = isa_pkg::FMT_RS_ONLY;
                tag    = isa_pkg::EXEC;  // link write goes through execute
            end
            isa_pkg::OP_MFHI, isa_pkg::OP_MFLO: begin
                format = isa_pkg::FMT_RD_ONLY;
                tag    = isa_pkg::EXEC;
            end
            isa_pkg::OP_SYSCALL: begin
                format = isa_pkg::FMT_NONE;
                tag    = isa_pkg::FLOW;
            end
            isa_pkg::OP_BREAK: begin
                format = isa_pkg::FMT_NONE;
                tag    = isa_pkg::EXEC;
            end
            default: begin
                format = isa_pkg::FMT_NONE;
                tag    = isa_pkg::INVALID;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/decode_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Decoded command layout: field types and the 88-bit command struct
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

package decode_pkg;

    typedef logic [`IF_ID_OP_W-1:0]   opcode_t;
    typedef logic [`IF_ID_REG_AW-1:0] reg_addr_t;
    typedef logic [`IF_ID_WORD_W-1:0] word_t;

    // field order from msb down matches the execute stage's view
    //   [87:82] opcode
    //   [81:77] rs
    //   [76:72] rt
    //   [71:67] rd
    //   [66:35] imm
    //   [34:3]  mem_addr
    //   [2:0]   tag
    typedef struct packed {
        opcode_t                opcode;
        reg_addr_t              rs;
        reg_addr_t              rt;
        reg_addr_t              rd;
        word_t                  imm;       // zero extended
        word_t                  mem_addr;  // register value for mem ops
        isa_pkg::route_tag_e    tag;
    } dec_cmd_t;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction set encodings: opcode values, operand formats
// and route tags used by the decode stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "if_id_config.svh"

package isa_pkg;

    // major opcodes of the kept instructions
    typedef enum logic [`IF_ID_OP_W-1:0] {
        OP_ADD     = 6'b000000,
        OP_SUB     = 6'b000001,
        OP_AND     = 6'b000010,
        OP_OR      = 6'b000011,
        OP_XOR     = 6'b000100,
        OP_SLT     = 6'b000101,
        OP_ADDI    = 6'b000110,
        OP_ANDI    = 6'b000111,
        OP_ORI     = 6'b001000,
        OP_LUI     = 6'b001001,
        OP_LW      = 6'b001010,  // load word
        OP_SW      = 6'b001011,  // store word
        OP_LB      = 6'b001100,  // load byte
        OP_SB      = 6'b001101,  // store byte
        OP_BEQ     = 6'b001110,
        OP_BNE     = 6'b001111,
        OP_BLEZ    = 6'b010000,
        OP_BGTZ    = 6'b010001,
        OP_J       = 6'b010010,
        OP_JAL     = 6'b010011,
        OP_SLL     = 6'b010110,
        OP_SRL     = 6'b010111,
        OP_SRA     = 6'b011000,
        OP_SLA     = 6'b011001,  // arithmetic left shift
        OP_SYSCALL = 6'b011010,
        OP_BREAK   = 6'b011011,
        OP_MFHI    = 6'b011100,
        OP_MFLO    = 6'b011101,
        OP_MULT    = 6'b011110,
        OP_DIV     = 6'b011111,
        OP_MOV     = 6'b101010,
        OP_NOR     = 6'b101011,
        OP_NOT     = 6'b101100
    } opcode_e;

    // which instruction fields land in rs, rt, rd and imm
    typedef enum logic [2:0] {
        FMT_NONE    = 3'd0,  // every field zero
        FMT_R3      = 3'd1,  // rs, rt, rd
        FMT_R2      = 3'd2,  // rs, rd
        FMT_RD_ONLY = 3'd3,
        FMT_RS_ONLY = 3'd4,
        FMT_IMM     = 3'd5,  // rs, rd from 20..16, 16-bit imm
        FMT_LUI     = 3'd6,  // rd from 25..21, 21-bit imm
        FMT_MEM     = 3'd7   // rt, rd plus register read
    } op_format_e;

    // downstream path selector
    typedef enum logic [`IF_ID_TAG_W-1:0] {
        INVALID  = 3'b000,
        MEM_PATH = 3'b001,
        EXEC     = 3'b010,
        FLOW     = 3'b011,
        LUI_PATH = 3'b110
    } route_tag_e;

endpackage

`default_nettype wire

// ==== logic/if_id_config.svh ====
////////////////////////////////////////////////////////////////////////////
// Width settings of the instruction decode stage:
// word, opcode, register address, immediate and route tag widths
////////////////////////////////////////////////////////////////////////////

`ifndef IF_ID_CONFIG_SVH
`define IF_ID_CONFIG_SVH

// instruction and data word
`define IF_ID_WORD_W 32

`define IF_ID_OP_W   6   // major opcode in the top bits
`define IF_ID_REG_AW 5   // register file address

// immediate fields
`define IF_ID_IMM_W  16  // I format
`define IF_ID_LUI_W  21  // LUI carries a wider field

`define IF_ID_TAG_W  3   // route tag of the decoded command

`endif
